// File: soc_macros.svh
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// cycles between heartbeat toggles
`define HEARTBEAT_CYCLES 64

// stable cycles before a key level is accepted
`define DEBOUNCE_CYCLES 8

// clock cycles per dac sample
`define DDS_DIV 4

// master gives up after this many cycles without ack/err
`define WB_TIMEOUT 16

// address map, value of adr[7:4]
`define GPIO_REGION 4'h0
`define DDS_REGION 4'h1

`endif

// File: wb_pkg.sv
`default_nettype none

package wb_pkg;

    // master to slave, classic cycle
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [7:0]  adr;
        logic [31:0] dat;
        logic [3:0]  sel;
    } wb_m2s_t;

    // slave to master
    typedef struct packed {
        logic        ack;
        logic        err;
        logic [31:0] dat;
    } wb_s2m_t;

    // host command, one bus cycle each
    typedef struct packed {
        logic        we;
        logic [7:0]  addr;
        logic [31:0] wdata;
    } dbg_cmd_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        err;
    } dbg_rsp_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUS,
        ST_RESP
    } master_state_e;

endpackage

`default_nettype wire

// File: periph_pkg.sv
`default_nettype none

package periph_pkg;

    // dds waveform select, code 3 falls back to saw
    typedef enum logic [1:0] {
        WAVE_SAW      = 2'd0,
        WAVE_SQUARE   = 2'd1,
        WAVE_TRIANGLE = 2'd2
    } wave_sel_e;

    // full byte address of each register
    // low nibble is the offset the slaves decode
    typedef enum logic [7:0] {
        REG_FPIOA  = 8'h00,
        REG_KEYS   = 8'h04,
        REG_KEYCLR = 8'h08,
        REG_TUNE   = 8'h10,
        REG_WAVE   = 8'h14,
        REG_EN     = 8'h18
    } reg_off_e;

endpackage

`default_nettype wire

// File: dbg_bus_master.sv
`timescale 1ns/1ns
`default_nettype none
`include "soc_macros.svh"

module dbg_bus_master (
    input  wire                   clk,
    input  wire                   reset,
    input  wire wb_pkg::dbg_cmd_t host_cmd,
    input  wire                   host_cmd_valid,
    output logic                  host_cmd_ready,
    output wb_pkg::dbg_rsp_t      host_rsp,
    output logic                  host_rsp_valid,
    output wb_pkg::wb_m2s_t       wb_out,
    input  wire wb_pkg::wb_s2m_t  wb_in
);
    import wb_pkg::*;

    localparam int TMO_W = $clog2(`WB_TIMEOUT);

    master_state_e    state;
    logic [TMO_W-1:0] tmo_cnt;
    logic             cyc_q;
    logic             we_q;
    logic [7:0]       adr_q;
    logic [31:0]      dat_q;
    logic             accept;
    logic             timed_out;
    logic             bus_done;

    // ready already low while a command is in flight
    assign accept    = (state == ST_IDLE) && host_cmd_valid && host_cmd_ready;
    assign timed_out = (tmo_cnt == TMO_W'(`WB_TIMEOUT - 1));
    assign bus_done  = wb_in.ack || wb_in.err || timed_out;

    // stb follows cyc, one cycle per transaction
    always_comb begin
        wb_out = '{cyc: cyc_q, stb: cyc_q, we: we_q, adr: adr_q, dat: dat_q, sel: 4'hf};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state          <= ST_IDLE;
            host_cmd_ready <= 1'b1;
            host_rsp_valid <= 1'b0;
            cyc_q          <= 1'b0;
            tmo_cnt        <= '0;
        end else begin
            host_rsp_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    // reopen the port the cycle after the pulse
                    if (host_rsp_valid) begin
                        host_cmd_ready <= 1'b1;
                    end else if (accept) begin
                        host_cmd_ready <= 1'b0;
                        cyc_q          <= 1'b1;
                        tmo_cnt        <= '0;
                        state          <= ST_BUS;
                    end
                end
                ST_BUS: begin
                    if (bus_done) begin
                        cyc_q <= 1'b0;
                        state <= ST_RESP;
                    end else begin
                        tmo_cnt <= tmo_cnt + 1'b1;
                    end
                end
                ST_RESP: begin
                    host_rsp_valid <= 1'b1;
                    state          <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // command and response payload
    always_ff @(posedge clk) begin
        if (accept) begin
            we_q  <= host_cmd.we;
            adr_q <= host_cmd.addr;
            dat_q <= host_cmd.wdata;
        end
        if (state == ST_BUS && bus_done) begin
            // ack wins, err or timeout report an error
            host_rsp <= '{rdata: wb_in.ack ? wb_in.dat : 32'h0, err: !wb_in.ack};
        end
    end

endmodule

`default_nettype wire

// File: gpio_led.sv
`timescale 1ns/1ns
`default_nettype none
`include "soc_macros.svh"

module gpio_led (
    input  wire                  clk,
    input  wire                  reset,
    input  wire wb_pkg::wb_m2s_t wb_in,
    input  wire                  stb,
    output wb_pkg::wb_s2m_t      wb_out,
    input  wire                  key0,
    input  wire                  key1,
    output logic [7:0]           fpioa,
    output logic                 led_int,
    output logic                 core_active
);
    import periph_pkg::*;

    localparam int DB_W = $clog2(`DEBOUNCE_CYCLES);
    localparam int HB_W = $clog2(`HEARTBEAT_CYCLES);

    logic [1:0]            key_meta;
    logic [1:0]            key_sync;
    logic [1:0]            key_level;
    logic [1:0]            key_flag;
    logic [DB_W-1:0]       db_cnt [2];
    logic [HB_W-1:0]       hb_cnt;
    logic                  ack_q;
    logic [31:0]           rdata_q;
    logic                  wr_en;
    logic [1:0]            flag_clr;

    // new access, not the ack cycle
    assign wr_en    = stb && wb_in.we && !ack_q;
    assign flag_clr = (wr_en && wb_in.adr[3:0] == REG_KEYCLR[3:0] && wb_in.sel[0])
                      ? wb_in.dat[1:0] : 2'b00;
    assign led_int  = |key_flag;

    always_comb begin
        wb_out = '{ack: ack_q, err: 1'b0, dat: rdata_q};
    end

    // two-flop synchroniser, then debounce per key
    always_ff @(posedge clk) begin
        if (reset) begin
            key_meta  <= 2'b00;
            key_sync  <= 2'b00;
            key_level <= 2'b00;
            key_flag  <= 2'b00;
            db_cnt[0] <= '0;
            db_cnt[1] <= '0;
        end else begin
            key_meta <= {key1, key0};
            key_sync <= key_meta;
            for (int i = 0; i < 2; i++) begin
                if (key_sync[i] == key_level[i]) begin
                    db_cnt[i] <= '0;
                end else if (db_cnt[i] == DB_W'(`DEBOUNCE_CYCLES - 1)) begin
                    db_cnt[i]    <= '0;
                    key_level[i] <= key_sync[i];
                end else begin
                    db_cnt[i] <= db_cnt[i] + 1'b1;
                end
            end
            // accepted rising level sets the flag, set beats clear
            for (int i = 0; i < 2; i++) begin
                if (key_sync[i] && !key_level[i] &&
                    db_cnt[i] == DB_W'(`DEBOUNCE_CYCLES - 1)) begin
                    key_flag[i] <= 1'b1;
                end else if (flag_clr[i]) begin
                    key_flag[i] <= 1'b0;
                end
            end
        end
    end

    // bus slave, fpioa register and heartbeat
    always_ff @(posedge clk) begin
        if (reset) begin
            ack_q       <= 1'b0;
            fpioa       <= 8'h00;
            hb_cnt      <= '0;
            core_active <= 1'b0;
        end else begin
            ack_q <= stb && !ack_q;
            if (wr_en && wb_in.adr[3:0] == REG_FPIOA[3:0] && wb_in.sel[0]) begin
                fpioa <= wb_in.dat[7:0];
            end
            if (hb_cnt == HB_W'(`HEARTBEAT_CYCLES - 1)) begin
                hb_cnt      <= '0;
                core_active <= !core_active;
            end else begin
                hb_cnt <= hb_cnt + 1'b1;
            end
        end
    end

    // read data registered alongside ack
    always_ff @(posedge clk) begin
        case (wb_in.adr[3:0])
            REG_FPIOA[3:0]: rdata_q <= {24'h0, fpioa};
            REG_KEYS[3:0]:  rdata_q <= {28'h0, key_flag, key_level};
            default:        rdata_q <= 32'h0;
        endcase
    end

endmodule

`default_nettype wire

// File: dds_gen.sv
`timescale 1ns/1ns
`default_nettype none
`include "soc_macros.svh"

module dds_gen (
    input  wire                  clk,
    input  wire                  reset,
    input  wire wb_pkg::wb_m2s_t wb_in,
    input  wire                  stb,
    output wb_pkg::wb_s2m_t      wb_out,
    output logic                 dac_clk,
    output logic [7:0]           dac_data
);
    import periph_pkg::*;

    localparam int DIV_W = $clog2(`DDS_DIV);

    logic [31:0]      tune;
    wave_sel_e        wave;
    logic             enable;
    logic [31:0]      phase;
    logic [31:0]      phase_next;
    logic [7:0]       sample;
    logic [DIV_W-1:0] div_cnt;
    logic             sample_stb;
    logic             ack_q;
    logic [31:0]      rdata_q;
    logic             wr_en;

    assign wr_en      = stb && wb_in.we && !ack_q;
    assign sample_stb = enable && (div_cnt == DIV_W'(`DDS_DIV - 1));
    assign phase_next = phase + tune;

    always_comb begin
        wb_out = '{ack: ack_q, err: 1'b0, dat: rdata_q};
    end

    // waveform lookup from the updated phase
    always_comb begin
        case (wave)
            WAVE_SQUARE:   sample = phase_next[31] ? 8'hff : 8'h00;
            WAVE_TRIANGLE: sample = phase_next[31] ? ~phase_next[30:23] : phase_next[30:23];
            default:       sample = phase_next[31:24];
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ack_q    <= 1'b0;
            tune     <= 32'h0;
            wave     <= WAVE_SAW;
            enable   <= 1'b0;
            phase    <= 32'h0;
            div_cnt  <= '0;
            dac_clk  <= 1'b0;
            dac_data <= 8'h00;
        end else begin
            ack_q <= stb && !ack_q;
            if (wr_en) begin
                case (wb_in.adr[3:0])
                    REG_TUNE[3:0]: begin
                        // byte lanes honoured for the tuning word
                        for (int b = 0; b < 4; b++) begin
                            if (wb_in.sel[b]) tune[8*b +: 8] <= wb_in.dat[8*b +: 8];
                        end
                    end
                    REG_WAVE[3:0]: if (wb_in.sel[0]) wave <= wave_sel_e'(wb_in.dat[1:0]);
                    REG_EN[3:0]:   if (wb_in.sel[0]) enable <= wb_in.dat[0];
                    default: ;
                endcase
            end
            // divider idles at zero while disabled
            div_cnt <= (enable && !sample_stb) ? div_cnt + 1'b1 : '0;
            dac_clk <= sample_stb;
            if (sample_stb) begin
                phase    <= phase_next;
                dac_data <= sample;
            end
        end
    end

    always_ff @(posedge clk) begin
        case (wb_in.adr[3:0])
            REG_TUNE[3:0]: rdata_q <= tune;
            REG_WAVE[3:0]: rdata_q <= {30'h0, wave};
            REG_EN[3:0]:   rdata_q <= {31'h0, enable};
            default:       rdata_q <= 32'h0;
        endcase
    end

endmodule

`default_nettype wire

// File: sparrow_soc.sv
`timescale 1ns/1ns
`default_nettype none
`include "soc_macros.svh"

module sparrow_soc (
    input  wire                   clk,
    input  wire                   reset,
    input  wire wb_pkg::dbg_cmd_t host_cmd,
    input  wire                   host_cmd_valid,
    output wire                   host_cmd_ready,
    output wb_pkg::dbg_rsp_t      host_rsp,
    output wire                   host_rsp_valid,
    input  wire                   key0,
    input  wire                   key1,
    output wire                   core_active,
    output wire                   led_int,
    output wire [7:0]             fpioa,
    output wire                   dac_clk,
    output wire [7:0]             dac_data
);
    import wb_pkg::*;

    wb_m2s_t    m2s;
    wb_s2m_t    s2m;
    wb_s2m_t    gpio_s2m;
    wb_s2m_t    dds_s2m;
    logic [3:0] region;
    logic       bus_req;
    logic       gpio_stb;
    logic       dds_stb;
    logic       unmapped;
    logic       dec_err;

    // region select from adr[7:4]
    assign region   = m2s.adr[7:4];
    assign bus_req  = m2s.cyc && m2s.stb;
    assign gpio_stb = bus_req && (region == `GPIO_REGION);
    assign dds_stb  = bus_req && (region == `DDS_REGION);
    assign unmapped = bus_req && !(region == `GPIO_REGION || region == `DDS_REGION);

    // err for holes in the map, same timing as a slave ack
    always_ff @(posedge clk) begin
        if (reset) begin
            dec_err <= 1'b0;
        end else begin
            dec_err <= unmapped && !dec_err;
        end
    end

    // return path of the addressed slave
    always_comb begin
        case (region)
            `GPIO_REGION: s2m = gpio_s2m;
            `DDS_REGION:  s2m = dds_s2m;
            default:      s2m = '{ack: 1'b0, err: dec_err, dat: 32'h0};
        endcase
    end

    dbg_bus_master u_master (
        .clk            (clk),
        .reset          (reset),
        .host_cmd       (host_cmd),
        .host_cmd_valid (host_cmd_valid),
        .host_cmd_ready (host_cmd_ready),
        .host_rsp       (host_rsp),
        .host_rsp_valid (host_rsp_valid),
        .wb_out         (m2s),
        .wb_in          (s2m)
    );

    gpio_led u_gpio (
        .clk         (clk),
        .reset       (reset),
        .wb_in       (m2s),
        .stb         (gpio_stb),
        .wb_out      (gpio_s2m),
        .key0        (key0),
        .key1        (key1),
        .fpioa       (fpioa),
        .led_int     (led_int),
        .core_active (core_active)
    );

    dds_gen u_dds (
        .clk      (clk),
        .reset    (reset),
        .wb_in    (m2s),
        .stb      (dds_stb),
        .wb_out   (dds_s2m),
        .dac_clk  (dac_clk),
        .dac_data (dac_data)
    );

endmodule

`default_nettype wire

// File: top.sv
`timescale 1ns/1ns
`default_nettype none

module top (
    input  wire                   clk,
    input  wire                   reset,
    // host debug port
    input  wire wb_pkg::dbg_cmd_t host_cmd,
    input  wire                   host_cmd_valid,
    output wire                   host_cmd_ready,
    output wb_pkg::dbg_rsp_t      host_rsp,
    output wire                   host_rsp_valid,
    // board pins
    input  wire                   key0,
    input  wire                   key1,
    output wire                   core_active,
    output wire                   led_int,
    output wire [7:0]             fpioa,
    output wire                   dac_clk,
    output wire [7:0]             dac_data
);

    sparrow_soc u_sparrow_soc (
        .clk            (clk),
        .reset          (reset),
        .host_cmd       (host_cmd),
        .host_cmd_valid (host_cmd_valid),
        .host_cmd_ready (host_cmd_ready),
        .host_rsp       (host_rsp),
        .host_rsp_valid (host_rsp_valid),
        .key0           (key0),
        .key1           (key1),
        .core_active    (core_active),
        .led_int        (led_int),
        .fpioa          (fpioa),
        .dac_clk        (dac_clk),
        .dac_data       (dac_data)
    );

endmodule

`default_nettype wire

// File: tb_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "soc_macros.svh"

module tb_top;
    import wb_pkg::*;
    import periph_pkg::*;

    logic        clk = 1'b0;
    logic        reset;
    dbg_cmd_t    host_cmd;
    logic        host_cmd_valid;
    wire         host_cmd_ready;
    dbg_rsp_t    host_rsp;
    wire         host_rsp_valid;
    logic        key0;
    logic        key1;
    wire         core_active;
    wire         led_int;
    wire [7:0]   fpioa;
    wire         dac_clk;
    wire [7:0]   dac_data;

    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          test_err_base;
    string       test_name;
    logic [31:0] lfsr = 32'hf598_43a9;
    // expected fpioa pins after each write to REG_FPIOA
    logic [7:0]  last_fpioa = 8'h00;

    // 8 ns period
    always #4 clk = ~clk;

    top u_top (
        .clk            (clk),
        .reset          (reset),
        .host_cmd       (host_cmd),
        .host_cmd_valid (host_cmd_valid),
        .host_cmd_ready (host_cmd_ready),
        .host_rsp       (host_rsp),
        .host_rsp_valid (host_rsp_valid),
        .key0           (key0),
        .key1           (key1),
        .core_active    (core_active),
        .led_int        (led_int),
        .fpioa          (fpioa),
        .dac_clk        (dac_clk),
        .dac_data       (dac_data)
    );

    // taps x^32 + x^22 + x^2 + x + 1
    // new bit enters at bit 0
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = (val << 1) | lfsr[0];
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        test_err_base = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors == test_err_base) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: FAILED, %0d errors", test_name, errors - test_err_base);
        end
    endtask

    task automatic wait_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
        end
    endtask

    // one host command with ready and 3-edge latency checks
    task automatic run_cmd(input logic we, input logic [7:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic rerr);
        int n;
        int edges;
        rdata = 32'h0;
        rerr  = 1'b1;
        @(posedge clk);
        host_cmd       <= '{we: we, addr: addr, wdata: wdata};
        host_cmd_valid <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!host_cmd_ready && n < 20);
        assert (host_cmd_ready) else begin
            $display("host_cmd_ready stayed low for %0d cycles, addr %h", n, addr);
            errors++;
        end
        // this edge accepts the command
        @(posedge clk);
        host_cmd_valid <= 1'b0;
        edges = 0;
        @(negedge clk);
        while (!host_rsp_valid && edges < `WB_TIMEOUT + 8) begin
            check_value("host_cmd_ready", host_cmd_ready, 1'b0);
            @(posedge clk);
            edges++;
            @(negedge clk);
        end
        assert (host_rsp_valid) else begin
            $display("no response after %0d cycles, addr %h", edges, addr);
            errors++;
        end
        check_value("host_cmd_ready", host_cmd_ready, 1'b0);
        check_value("host_rsp_valid latency", edges, 3);
        rdata = host_rsp.rdata;
        rerr  = host_rsp.err;
        if (we && addr == REG_FPIOA) begin
            last_fpioa = wdata[7:0];
        end
        check_value("fpioa", fpioa, last_fpioa);
    endtask

    task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic        er;
        run_cmd(1'b1, addr, data, rd, er);
        check_value("host_rsp.err", er, 1'b0);
    endtask

    task automatic bus_read(input logic [7:0] addr, output logic [31:0] data);
        logic er;
        run_cmd(1'b0, addr, 32'h0, data, er);
        check_value("host_rsp.err", er, 1'b0);
    endtask

    // core_active period counted from the edge that drops reset
    task automatic check_heartbeat();
        int   n;
        logic prev;
        start_test("heartbeat");
        for (int t = 0; t < 3; t++) begin
            prev = core_active;
            n    = 0;
            do begin
                @(posedge clk);
                n++;
                @(negedge clk);
            end while (core_active == prev && n < 2 * `HEARTBEAT_CYCLES);
            assert (core_active != prev) else begin
                $display("core_active did not toggle within %0d cycles", n);
                errors++;
            end
            check_value("core_active interval", n, `HEARTBEAT_CYCLES);
        end
        finish_test();
    endtask

    task automatic run_file_tests();
        int          fd;
        int          cnt;
        int          n;
        string       line;
        string       op;
        logic [7:0]  addr;
        logic [31:0] wdata;
        logic [31:0] exp_rdata;
        logic        exp_err;
        logic [31:0] rdata;
        logic        rerr;
        cnt = 0;
        fd  = $fopen("tb_input.txt", "r");
        assert (fd != 0) else begin
            $display("cannot open tb_input.txt");
            errors++;
        end
        while (fd != 0 && !$feof(fd)) begin
            line = "";
            n    = $fgets(line, fd);
            // comments and blank lines
            if (line.len() == 0 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %h %h %h %h", op, addr, wdata, exp_rdata, exp_err);
            if (n != 5) begin
                continue;
            end
            run_cmd(op == "w", addr, wdata, rdata, rerr);
            check_value("host_rsp.err", rerr, exp_err);
            // write responses carry no defined data
            if (op == "r") begin
                check_value("host_rsp.rdata", rdata, exp_rdata);
            end
            cnt++;
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        assert (cnt > 0) else begin
            $display("no bus commands found in tb_input.txt");
            errors++;
        end
    endtask

    task automatic pulse_key(input int which, input int len);
        @(posedge clk);
        if (which == 0) begin
            key0 <= 1'b1;
        end else begin
            key1 <= 1'b1;
        end
        wait_cycles(len);
        key0 <= 1'b0;
        key1 <= 1'b0;
    endtask

    // press long enough to pass the debouncer, then clear the flag
    task automatic check_key_press(input int which);
        int          r;
        int          n;
        logic [31:0] rd;
        draw_bits(4, r);
        pulse_key(which, `DEBOUNCE_CYCLES + 4 + r);
        // poll until the debounced level is low again
        n  = 0;
        rd = 32'h3;
        while (rd[1:0] != 2'b00 && n < 10) begin
            bus_read(REG_KEYS, rd);
            n++;
        end
        assert (rd[1:0] == 2'b00) else begin
            $display("key%0d level still high after %0d reads", which, n);
            errors++;
        end
        // flags sit in bits 3:2
        check_value("keys", rd, 32'h4 << which);
        check_value("led_int", led_int, 1'b1);
        bus_write(REG_KEYCLR, 32'h1 << which);
        bus_read(REG_KEYS, rd);
        check_value("keys", rd, 32'h0);
        check_value("led_int", led_int, 1'b0);
    endtask

    task automatic check_glitch();
        int          r;
        logic [31:0] rd;
        draw_bits(3, r);
        // 1 to DEBOUNCE_CYCLES-1 cycles high
        pulse_key(0, 1 + r % (`DEBOUNCE_CYCLES - 1));
        wait_cycles(2 * `DEBOUNCE_CYCLES + 4);
        bus_read(REG_KEYS, rd);
        check_value("keys", rd, 32'h0);
        check_value("led_int", led_int, 1'b0);
    endtask

    task automatic wait_dac_pulse(output int gap);
        gap = 0;
        do begin
            @(posedge clk);
            gap++;
            @(negedge clk);
        end while (!dac_clk && gap < 4 * `DDS_DIV);
        assert (dac_clk) else begin
            $display("no dac_clk pulse within %0d cycles", gap);
            errors++;
        end
    endtask

    task automatic check_dds();
        int         gap;
        logic [7:0] prev;
        logic [7:0] expected;
        bit         seen_low;
        bit         seen_high;
        bus_write(REG_TUNE, 32'h0300_0000);
        bus_write(REG_WAVE, WAVE_SAW);
        bus_write(REG_EN, 32'h1);
        wait_dac_pulse(gap);
        prev = dac_data;
        // saw steps by tune[31:24] per sample
        for (int i = 0; i < 8; i++) begin
            wait_dac_pulse(gap);
            expected = prev + 8'd3;
            check_value("dac_data", dac_data, expected);
            check_value("dac_clk period", gap, `DDS_DIV);
            prev = dac_data;
        end
        // quarter turn per sample so both levels show up
        bus_write(REG_TUNE, 32'h4000_0000);
        bus_write(REG_WAVE, WAVE_SQUARE);
        seen_low  = 1'b0;
        seen_high = 1'b0;
        for (int i = 0; i < 12; i++) begin
            wait_dac_pulse(gap);
            assert (dac_data == 8'h00 || dac_data == 8'hff) else begin
                $display("MISMATCH dac_data: got %h, expected 00 or ff", dac_data);
                errors++;
            end
            seen_low  = seen_low | (dac_data == 8'h00);
            seen_high = seen_high | (dac_data == 8'hff);
        end
        assert (seen_low && seen_high) else begin
            $display("square output did not reach both levels");
            errors++;
        end
        bus_write(REG_EN, 32'h0);
    endtask

    initial begin
        reset          = 1'b1;
        host_cmd       = '0;
        host_cmd_valid = 1'b0;
        key0           = 1'b0;
        key1           = 1'b0;

        // reset held over 5 rising edges
        start_test("reset values");
        wait_cycles(4);
        @(negedge clk);
        check_value("host_cmd_ready", host_cmd_ready, 1'b1);
        check_value("host_rsp_valid", host_rsp_valid, 1'b0);
        check_value("core_active", core_active, 1'b0);
        check_value("led_int", led_int, 1'b0);
        check_value("fpioa", fpioa, 8'h00);
        check_value("dac_clk", dac_clk, 1'b0);
        check_value("dac_data", dac_data, 8'h00);
        @(posedge clk);
        reset <= 1'b0;
        finish_test();

        // must start right at the reset edge
        check_heartbeat();

        start_test("bus commands from file");
        run_file_tests();
        finish_test();

        start_test("keys");
        check_key_press(0);
        check_key_press(1);
        check_glitch();
        finish_test();

        start_test("dds");
        check_dds();
        finish_test();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_input.txt
# columns: op addr wdata expected_rdata expected_err, values in hex
# op w = write, r = read, expected_rdata is compared on reads only
w 00 000000a5 00000000 0
r 00 00000000 000000a5 0
w 00 12345678 00000000 0
r 00 00000000 00000078 0
r 04 00000000 00000000 0
r 0c 00000000 00000000 0
w 10 03000000 00000000 0
r 10 00000000 03000000 0
w 10 deadbeef 00000000 0
r 10 00000000 deadbeef 0
w 14 00000002 00000000 0
r 14 00000000 00000002 0
w 14 ffffffff 00000000 0
r 14 00000000 00000003 0
w 18 ffffffff 00000000 0
r 18 00000000 00000001 0
w 18 00000000 00000000 0
r 18 00000000 00000000 0
w 14 00000000 00000000 0
w 20 12345678 00000000 1
r 2c 00000000 00000000 1
r f0 00000000 00000000 1

// File: flist.f
+incdir+.
wb_pkg.sv
periph_pkg.sv
dbg_bus_master.sv
gpio_led.sv
dds_gen.sv
sparrow_soc.sv
top.sv
tb_top.sv
